//--- Makefile
sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f verilog.f --top-module tb_soc_mem_top -o sim_tb
	./obj_dir/sim_tb 2>&1 | tee sim.log
	@if grep -q "tests failed" sim.log; then exit 1; fi
	@grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

//--- rtl/boot_cfg_sequencer.sv
`timescale 1ns/1ps

module boot_cfg_sequencer
   import soc_mem_pkg::*;
  (input clk_i
   , input rst_n_i

   // Normal requester, held off until boot is done
   , mem_chan_if.responder host

   // Shared path toward the bridge
   , mem_chan_if.requester bus

   , output logic boot_done_o
   );

   // Loader FSM
   typedef enum logic
   {
      e_send = 1'b0,
      e_wait = 1'b1
   } seq_state_e;

   seq_state_e                  state_r;
   logic [cfg_idx_width_lp-1:0] idx_r;
   logic                        done_r;
   logic                        last_entry;

   // Loader side of the hand-over mux
   mem_msg_s cfg_cmd;
   logic     cfg_cmd_v;
   logic     cfg_resp_yumi;

   assign last_entry = (idx_r == cfg_idx_width_lp'(cfg_entries_lp - 1));

   // Full dword write of the current table entry
   always_comb
   begin
      cfg_cmd.op   = e_mem_wr;
      cfg_cmd.size = e_size_8;
      cfg_cmd.err  = 1'b0;
      cfg_cmd.addr = cfg_addr_table_lp[idx_r];
      cfg_cmd.data = cfg_data_table_lp[idx_r];
   end

   // Only one write outstanding at a time
   assign cfg_cmd_v = (state_r == e_send) & ~done_r;

   // Response is taken the cycle it shows up
   assign cfg_resp_yumi = (state_r == e_wait) & bus.resp_v;

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         state_r <= e_send;
         idx_r   <= '0;
         done_r  <= 1'b0;
      end
      else
      begin
         case (state_r)
            e_send:
            begin
               // Command handed to the bridge
               if (cfg_cmd_v && bus.cmd_ready)
               begin
                  state_r <= e_wait;
               end
            end
            e_wait:
            begin
               if (cfg_resp_yumi)
               begin
                  state_r <= e_send;
                  if (last_entry)
                  begin
                     // Table exhausted, open the host port
                     done_r <= 1'b1;
                  end
                  else
                  begin
                     idx_r <= idx_r + 1'b1;
                  end
               end
            end
            default:
            begin
               state_r <= e_send;
            end
         endcase
      end
   end

   assign boot_done_o = done_r;

   // Fixed hand-over keyed on done
   // Loader owns the bus first, then the host is wired straight through
   always_comb
   begin
      if (!done_r)
      begin
         bus.cmd        = cfg_cmd;
         bus.cmd_v      = cfg_cmd_v;
         bus.resp_yumi  = cfg_resp_yumi;

         host.cmd_ready = 1'b0;
         host.resp      = '0;
         host.resp_v    = 1'b0;
      end
      else
      begin
         bus.cmd        = host.cmd;
         bus.cmd_v      = host.cmd_v;
         bus.resp_yumi  = host.resp_yumi;

         host.cmd_ready = bus.cmd_ready;
         host.resp      = bus.resp;
         host.resp_v    = bus.resp_v;
      end
   end

   // Host port opens onto an idle bridge
   a_handover_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $rose(done_r) |-> bus.cmd_ready);

   // Config space must never fault on a loader write
   a_cfg_write_no_err: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (bus.resp_v && !done_r) |-> !bus.resp.err);

endmodule

//--- rtl/mem_chan_if.sv
`timescale 1ns/1ps

interface mem_chan_if
   import soc_mem_pkg::*;
   ();

   // Command direction, valid/ready
   mem_msg_s cmd;
   logic     cmd_v;
   logic     cmd_ready;

   // Response direction, valid/yumi
   // Response holds until yumi arrives with valid
   mem_msg_s resp;
   logic     resp_v;
   logic     resp_yumi;

   // Side that issues commands and consumes responses
   modport requester
     (output cmd
      , output cmd_v
      , input  cmd_ready
      , input  resp
      , input  resp_v
      , output resp_yumi
      );

   // Side that serves commands
   modport responder
     (input  cmd
      , input  cmd_v
      , output cmd_ready
      , output resp
      , output resp_v
      , input  resp_yumi
      );

endinterface

//--- rtl/mem_wb_bridge.sv
`timescale 1ns/1ps

module mem_wb_bridge
   import soc_mem_pkg::*;
  (input clk_i
   , input rst_n_i

   // Channel from the sequencer
   , mem_chan_if.responder chan

   // Wishbone master, classic cycles
   , input  logic [dword_width_lp-1:0]  wbm_dat_i
   , output logic [dword_width_lp-1:0]  wbm_dat_o
   , output logic [wb_adr_width_lp-1:0] wbm_adr_o
   , output logic [wb_sel_width_lp-1:0] wbm_sel_o
   , output logic                       wbm_we_o
   , output logic                       wbm_stb_o
   , output logic                       wbm_cyc_o
   , input  logic                       wbm_ack_i
   , input  logic                       wbm_err_i
   );

   typedef enum logic [1:0]
   {
      e_idle = 2'd0,
      e_bus  = 2'd1,
      e_resp = 2'd2
   } bridge_state_e;

   bridge_state_e state_r;

   // Accepted command, held for the whole transaction
   mem_msg_s cmd_r;

   // Captured response payload
   logic [dword_width_lp-1:0] resp_data_r;
   logic                      resp_err_r;

   logic                       cmd_fire;
   logic                       bus_done;
   logic [2:0]                 byte_off;
   logic [wb_sel_width_lp-1:0] size_mask;
   logic [dword_width_lp-1:0]  data_mask;
   logic [dword_width_lp-1:0]  rd_data;

   assign chan.cmd_ready = (state_r == e_idle);
   assign cmd_fire       = chan.cmd_v & chan.cmd_ready;

   // Ack and err both end the cycle
   assign bus_done = (state_r == e_bus) & (wbm_ack_i | wbm_err_i);

   assign byte_off = cmd_r.addr[2:0];

   // Low lanes covered by the transfer size
   always_comb
   begin
      case (cmd_r.size)
         e_size_1: size_mask = 8'h01;
         e_size_2: size_mask = 8'h03;
         e_size_4: size_mask = 8'h0f;
         default:  size_mask = 8'hff;
      endcase
   end

   // Byte lanes widened to a bit mask
   always_comb
   begin
      for (int i = 0; i < wb_sel_width_lp; i++)
      begin
         data_mask[8*i +: 8] = {8{size_mask[i]}};
      end
   end

   // Read bytes brought down to the low end, zero above the size
   assign rd_data = (wbm_dat_i >> {byte_off, 3'b000}) & data_mask;

   // Bus side of the registered command
   assign wbm_adr_o = cmd_r.addr[paddr_width_lp-1:3];
   assign wbm_sel_o = size_mask << byte_off;
   assign wbm_dat_o = cmd_r.data << {byte_off, 3'b000};
   assign wbm_cyc_o = (state_r == e_bus);
   assign wbm_stb_o = (state_r == e_bus);
   assign wbm_we_o  = (state_r == e_bus) & (cmd_r.op == e_mem_wr);

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         state_r <= e_idle;
      end
      else
      begin
         case (state_r)
            e_idle:
            begin
               if (cmd_fire)
               begin
                  state_r <= e_bus;
               end
            end
            e_bus:
            begin
               if (bus_done)
               begin
                  state_r <= e_resp;
               end
            end
            e_resp:
            begin
               // Idle again right after the response is consumed
               if (chan.resp_yumi)
               begin
                  state_r <= e_idle;
               end
            end
            default:
            begin
               state_r <= e_idle;
            end
         endcase
      end
   end

   // Payload registers
   always_ff @(posedge clk_i)
   begin
      if (cmd_fire)
      begin
         cmd_r <= chan.cmd;
      end
      if (bus_done)
      begin
         resp_err_r <= wbm_err_i;
         // Writes and faults return no data
         if ((cmd_r.op == e_mem_rd) && !wbm_err_i)
         begin
            resp_data_r <= rd_data;
         end
         else
         begin
            resp_data_r <= '0;
         end
      end
   end

   // Response echoes the command header
   always_comb
   begin
      chan.resp.op   = cmd_r.op;
      chan.resp.size = cmd_r.size;
      chan.resp.err  = resp_err_r;
      chan.resp.addr = cmd_r.addr;
      chan.resp.data = resp_data_r;
   end

   assign chan.resp_v = (state_r == e_resp);

   // Slave never answers both ways at once
   a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(wbm_ack_i && wbm_err_i));

   // Offset bits below the size must be zero
   a_cmd_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      cmd_fire |->
         (({1'b0, chan.cmd.addr[2:0]} & ((4'd1 << chan.cmd.size) - 4'd1)) == 4'd0));

   // Answer only inside a cycle
   a_resp_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (wbm_ack_i || wbm_err_i) |-> wbm_cyc_o);

endmodule

//--- rtl/soc_mem_pkg.sv
package soc_mem_pkg;

   // Physical address and data widths of the memory channel
   localparam int paddr_width_lp  = 40;
   localparam int dword_width_lp  = 64;

   // Wishbone addresses whole dwords, so the three byte bits go away
   localparam int wb_adr_width_lp = paddr_width_lp - 3;
   localparam int wb_sel_width_lp = dword_width_lp / 8;

   // Boot configuration table
   localparam int cfg_entries_lp   = 4;
   localparam int cfg_idx_width_lp = $clog2(cfg_entries_lp);

   // All entries sit inside the configuration space
   localparam logic [paddr_width_lp-1:0] cfg_addr_table_lp [cfg_entries_lp] = '{
      40'h00_0020_0100,
      40'h00_0020_0108,
      40'h00_0020_0110,
      40'h00_0020_0118
   };

   // Coherence mode, hart id, DRAM base, then the freeze word
   localparam logic [dword_width_lp-1:0] cfg_data_table_lp [cfg_entries_lp] = '{
      64'h0000_0000_0000_0001,
      64'h0000_0000_0000_0000,
      64'h0000_0000_8000_0000,
      // Writing zero here releases the freeze
      64'h0000_0000_0000_0000
   };

   // Start of the region where the slave answers with err
   localparam logic [paddr_width_lp-1:0] err_base_addr_lp = 40'h80_0000_0000;

   // Operation of a channel message
   typedef enum logic
   {
      e_mem_rd = 1'b0,
      e_mem_wr = 1'b1
   } mem_op_e;

   // Transfer is 2**size bytes
   typedef enum logic [1:0]
   {
      e_size_1 = 2'd0,
      e_size_2 = 2'd1,
      e_size_4 = 2'd2,
      e_size_8 = 2'd3
   } mem_size_e;

   // Same layout for commands and responses
   // Data is always right-justified in the low bytes
   typedef struct packed
   {
      mem_op_e                   op;
      mem_size_e                 size;
      logic                      err;
      logic [paddr_width_lp-1:0] addr;
      logic [dword_width_lp-1:0] data;
   } mem_msg_s;

endpackage

//--- rtl/soc_mem_top.sv
`timescale 1ns/1ps

module soc_mem_top
   import soc_mem_pkg::*;
  (input clk_i
   , input rst_n_i

   // Host memory channel
   , input  mem_msg_s host_cmd_i
   , input  logic     host_cmd_v_i
   , output logic     host_cmd_ready_o

   , output mem_msg_s host_resp_o
   , output logic     host_resp_v_o
   , input  logic     host_resp_yumi_i

   // High once the configuration table is written
   , output logic boot_done_o

   // Wishbone master
   , input  logic [dword_width_lp-1:0]  wbm_dat_i
   , output logic [dword_width_lp-1:0]  wbm_dat_o
   , output logic [wb_adr_width_lp-1:0] wbm_adr_o
   , output logic [wb_sel_width_lp-1:0] wbm_sel_o
   , output logic                       wbm_we_o
   , output logic                       wbm_stb_o
   , output logic                       wbm_cyc_o
   , input  logic                       wbm_ack_i
   , input  logic                       wbm_err_i
   );

   // Host side, into the loader
   mem_chan_if host_chan ();

   // Loader or host, into the bridge
   mem_chan_if bus_chan ();

   // Host ports onto the channel
   assign host_chan.cmd       = host_cmd_i;
   assign host_chan.cmd_v     = host_cmd_v_i;
   assign host_cmd_ready_o    = host_chan.cmd_ready;

   assign host_resp_o         = host_chan.resp;
   assign host_resp_v_o       = host_chan.resp_v;
   assign host_chan.resp_yumi = host_resp_yumi_i;

   // Boot writes first, then host traffic
   boot_cfg_sequencer
    boot_cfg_sequencer_inst
     (.clk_i(clk_i)
      ,.rst_n_i(rst_n_i)

      ,.host(host_chan.responder)
      ,.bus(bus_chan.requester)

      ,.boot_done_o(boot_done_o)
      );

   // One dword per Wishbone cycle
   mem_wb_bridge
    mem_wb_bridge_inst
     (.clk_i(clk_i)
      ,.rst_n_i(rst_n_i)

      ,.chan(bus_chan.responder)

      ,.wbm_dat_i(wbm_dat_i)
      ,.wbm_dat_o(wbm_dat_o)
      ,.wbm_adr_o(wbm_adr_o)
      ,.wbm_sel_o(wbm_sel_o)
      ,.wbm_we_o(wbm_we_o)
      ,.wbm_stb_o(wbm_stb_o)
      ,.wbm_cyc_o(wbm_cyc_o)
      ,.wbm_ack_i(wbm_ack_i)
      ,.wbm_err_i(wbm_err_i)
      );

endmodule

//--- tb/tb_soc_mem_top.sv
`timescale 1ns/1ps

module tb_soc_mem_top
   import soc_mem_pkg::*;
  ();

   localparam int timeout_cycles_lp = 100;

   typedef struct packed
   {
      mem_op_e                   op;
      mem_size_e                 size;
      logic [paddr_width_lp-1:0] addr;
      logic [dword_width_lp-1:0] wdata;
      logic [dword_width_lp-1:0] exp_data;
      logic                      exp_err;
      logic [3:0]                yumi_dly;
   } stim_s;

   logic     clk_i = 1'b0;
   logic     rst_n_i;
   mem_msg_s host_cmd_i;
   logic     host_cmd_v_i;
   logic     host_cmd_ready_o;
   mem_msg_s host_resp_o;
   logic     host_resp_v_o;
   logic     host_resp_yumi_i;
   logic     boot_done_o;

   logic [dword_width_lp-1:0]  wbm_dat_i;
   logic [dword_width_lp-1:0]  wbm_dat_o;
   logic [wb_adr_width_lp-1:0] wbm_adr_o;
   logic [wb_sel_width_lp-1:0] wbm_sel_o;
   logic                       wbm_we_o;
   logic                       wbm_stb_o;
   logic                       wbm_cyc_o;
   logic                       wbm_ack_i;
   logic                       wbm_err_i;

   stim_s stim_q [$];
   string name_q [$];
   // Expected memory contents, keyed by dword address
   logic [dword_width_lp-1:0] shadow [logic [wb_adr_width_lp-1:0]];
   int err_cnt;
   int timeout_cnt;

   always #2 clk_i = ~clk_i;

   soc_mem_top soc_mem_top_inst (.*);

   tb_wb_mem wb_mem_inst
     (.clk_i(clk_i)
      ,.rst_n_i(rst_n_i)
      ,.adr_i(wbm_adr_o)
      ,.dat_i(wbm_dat_o)
      ,.dat_o(wbm_dat_i)
      ,.sel_i(wbm_sel_o)
      ,.we_i(wbm_we_o)
      ,.stb_i(wbm_stb_o)
      ,.cyc_i(wbm_cyc_o)
      ,.ack_o(wbm_ack_i)
      ,.err_o(wbm_err_i)
      );

   // Classic cycle, strobe only inside cyc
   always @(negedge clk_i)
   begin
      if (rst_n_i)
      begin
         assert (!wbm_stb_o || wbm_cyc_o)
         else
         begin
            $display("Wishbone strobe raised outside a bus cycle");
            err_cnt++;
         end
      end
   end

   // Low bytes of a transfer as a bit mask
   function automatic logic [dword_width_lp-1:0] low_mask(input mem_size_e size);
      return (size == e_size_8) ? '1 : ((64'd1 << (8 << size)) - 64'd1);
   endfunction

   // Appends one access; expected data follows the lane rule on the shadow
   task automatic add_entry(input string name, input mem_op_e op, input mem_size_e size,
                            input logic [paddr_width_lp-1:0] addr,
                            input logic [dword_width_lp-1:0] wdata,
                            input logic exp_err, input logic [3:0] yumi_dly);
      stim_s                      s;
      logic [dword_width_lp-1:0]  lane;
      logic [dword_width_lp-1:0]  old;
      logic [5:0]                 shift;
      logic [wb_adr_width_lp-1:0] key;
      key        = addr[paddr_width_lp-1:3];
      shift      = {addr[2:0], 3'b000};
      lane       = low_mask(size) << shift;
      old        = shadow.exists(key) ? shadow[key] : '0;
      s.op       = op;
      s.size     = size;
      s.addr     = addr;
      s.wdata    = wdata;
      s.exp_err  = exp_err;
      s.yumi_dly = yumi_dly;
      s.exp_data = '0;
      if (!exp_err && op == e_mem_wr)
      begin
         shadow[key] = (old & ~lane) | ((wdata << shift) & lane);
      end
      else if (!exp_err)
      begin
         // Bytes from the offset upward, packed into the low end
         for (int b = 0; b < (1 << size); b++)
         begin
            s.exp_data[8*b +: 8] = old[8*(addr[2:0] + b) +: 8];
         end
      end
      stim_q.push_back(s);
      name_q.push_back(name);
   endtask

   task automatic build_table();
      add_entry("wr_full", e_mem_wr, e_size_8, 40'h00_1000_0040, 64'h0123_4567_89ab_cdef,
                1'b0, 4'd0);
      add_entry("rd_full", e_mem_rd, e_size_8, 40'h00_1000_0040, '0, 1'b0, 4'd1);
      add_entry("wr_base", e_mem_wr, e_size_8, 40'h00_1000_0050, 64'hfedc_ba98_7654_3210,
                1'b0, 4'd0);
      // Garbage above the size must not reach memory
      add_entry("wr_byte", e_mem_wr, e_size_1, 40'h00_1000_0051, 64'hffff_ffff_ffff_ffab,
                1'b0, 4'd0);
      add_entry("wr_half", e_mem_wr, e_size_2, 40'h00_1000_0052, 64'heeee_eeee_eeee_cdef,
                1'b0, 4'd2);
      add_entry("wr_word", e_mem_wr, e_size_4, 40'h00_1000_0054, 64'hdddd_dddd_1234_5678,
                1'b0, 4'd0);
      add_entry("rd_merge", e_mem_rd, e_size_8, 40'h00_1000_0050, '0, 1'b0, 4'd0);
      add_entry("rd_byte", e_mem_rd, e_size_1, 40'h00_1000_0051, '0, 1'b0, 4'd0);
      add_entry("rd_half", e_mem_rd, e_size_2, 40'h00_1000_0052, '0, 1'b0, 4'd1);
      add_entry("rd_word", e_mem_rd, e_size_4, 40'h00_1000_0054, '0, 1'b0, 4'd0);
      // Error region aliases index 9 in the model
      add_entry("wr_ref", e_mem_wr, e_size_8, 40'h00_1000_0048, 64'h0bad_f00d_cafe_0048,
                1'b0, 4'd0);
      add_entry("wr_err", e_mem_wr, e_size_8, err_base_addr_lp + 40'h48,
                64'h1111_2222_3333_4444, 1'b1, 4'd0);
      add_entry("rd_err", e_mem_rd, e_size_8, err_base_addr_lp + 40'h48, '0, 1'b1, 4'd3);
      add_entry("rd_ref", e_mem_rd, e_size_8, 40'h00_1000_0048, '0, 1'b0, 4'd0);
      add_entry("rd_backpressure", e_mem_rd, e_size_8, 40'h00_1000_0040, '0, 1'b0, 4'd6);
   endtask

   // Port stays shut during boot, then the log must match the table
   task automatic check_boot(output logic ok);
      int cycles;
      cycles = 0;
      ok     = 1'b1;
      while (!boot_done_o && cycles < timeout_cycles_lp)
      begin
         assert (!host_cmd_ready_o)
         else
         begin
            $display("host command port opened before boot was done");
            err_cnt++;
         end
         @(posedge clk_i);
         #1;
         cycles++;
      end
      if (!boot_done_o)
      begin
         $display("timeout while waiting for boot to finish");
         timeout_cnt++;
         ok = 1'b0;
         return;
      end
      assert (wb_mem_inst.log_adr.size() == cfg_entries_lp)
      else
      begin
         $display("error boot_writes: expected %0d, actual %0d", cfg_entries_lp,
                  wb_mem_inst.log_adr.size());
         err_cnt++;
         return;
      end
      for (int i = 0; i < cfg_entries_lp; i++)
      begin
         assert (wb_mem_inst.log_adr[i] == cfg_addr_table_lp[i][paddr_width_lp-1:3])
         else
         begin
            $display("error boot_adr[%0d]: expected %h, actual %h", i,
                     cfg_addr_table_lp[i][paddr_width_lp-1:3], wb_mem_inst.log_adr[i]);
            err_cnt++;
         end
         assert (wb_mem_inst.log_dat[i] == cfg_data_table_lp[i])
         else
         begin
            $display("error boot_dat[%0d]: expected %h, actual %h", i,
                     cfg_data_table_lp[i], wb_mem_inst.log_dat[i]);
            err_cnt++;
         end
         assert (wb_mem_inst.log_sel[i] == 8'hff)
         else
         begin
            $display("error boot_sel[%0d]: expected ff, actual %h", i, wb_mem_inst.log_sel[i]);
            err_cnt++;
         end
      end
   endtask

   // Called at a drive point, 1 ns after a rising edge
   task automatic run_entry(input int n, output logic ok);
      stim_s    s;
      mem_msg_s held;
      int       cycles;
      s                = stim_q[n];
      ok               = 1'b1;
      host_cmd_i.op    = s.op;
      host_cmd_i.size  = s.size;
      host_cmd_i.err   = 1'b0;
      host_cmd_i.addr  = s.addr;
      host_cmd_i.data  = s.wdata;
      host_cmd_v_i     = 1'b1;
      cycles = 0;
      while (!host_cmd_ready_o && cycles < timeout_cycles_lp)
      begin
         @(posedge clk_i);
         #1;
         cycles++;
      end
      if (!host_cmd_ready_o)
      begin
         $display("timeout: %s command was never accepted", name_q[n]);
         timeout_cnt++;
         ok = 1'b0;
         return;
      end
      // Transfers on the coming edge
      @(posedge clk_i);
      #1;
      host_cmd_v_i = 1'b0;
      cycles = 0;
      while (!host_resp_v_o && cycles < timeout_cycles_lp)
      begin
         @(posedge clk_i);
         #1;
         cycles++;
      end
      if (!host_resp_v_o)
      begin
         $display("timeout: %s got no response", name_q[n]);
         timeout_cnt++;
         ok = 1'b0;
         return;
      end
      held = host_resp_o;
      assert (held.err == s.exp_err)
      else
      begin
         $display("error %s err: expected %0b, actual %0b", name_q[n], s.exp_err, held.err);
         err_cnt++;
      end
      assert (held.data == s.exp_data)
      else
      begin
         $display("error %s data: expected %h, actual %h", name_q[n], s.exp_data, held.data);
         err_cnt++;
      end
      // Same command offered again, it must wait for the yumi
      host_cmd_v_i = (s.yumi_dly != 4'd0);
      // Response held, port shut, bus quiet until the yumi
      repeat (s.yumi_dly)
      begin
         @(posedge clk_i);
         #1;
         assert (host_resp_v_o && host_resp_o == held)
         else
         begin
            $display("error %s held resp: expected %h, actual %h", name_q[n], held, host_resp_o);
            err_cnt++;
         end
         assert (!host_cmd_ready_o && !wbm_cyc_o)
         else
         begin
            $display("%s: new traffic started while the response was pending", name_q[n]);
            err_cnt++;
         end
      end
      host_cmd_v_i     = 1'b0;
      host_resp_yumi_i = 1'b1;
      @(posedge clk_i);
      #1;
      host_resp_yumi_i = 1'b0;
   endtask

   initial
   begin
      logic ok;
      err_cnt          = 0;
      timeout_cnt      = 0;
      rst_n_i          = 1'b0;
      host_cmd_i       = '0;
      host_cmd_v_i     = 1'b0;
      host_resp_yumi_i = 1'b0;
      build_table();
      repeat (3) @(posedge clk_i);
      #1;
      rst_n_i = 1'b1;
      check_boot(ok);
      for (int n = 0; n < stim_q.size() && ok; n++)
      begin
         run_entry(n, ok);
      end
      $display("errors: %0d, timeouts: %0d", err_cnt, timeout_cnt);
      if (err_cnt == 0 && timeout_cnt == 0)
      begin
         $display("all tests passed");
      end
      else
      begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

//--- tb/tb_wb_mem.sv
`timescale 1ns/1ps

module tb_wb_mem
   import soc_mem_pkg::*;
  (input clk_i
   , input rst_n_i
   , input  logic [wb_adr_width_lp-1:0] adr_i
   , input  logic [dword_width_lp-1:0]  dat_i
   , output logic [dword_width_lp-1:0]  dat_o
   , input  logic [wb_sel_width_lp-1:0] sel_i
   , input  logic                       we_i
   , input  logic                       stb_i
   , input  logic                       cyc_i
   , output logic                       ack_o
   , output logic                       err_o
   );

   logic [dword_width_lp-1:0] mem [64];

   // Every acknowledged write, oldest first
   logic [wb_adr_width_lp-1:0] log_adr [$];
   logic [dword_width_lp-1:0]  log_dat [$];
   logic [wb_sel_width_lp-1:0] log_sel [$];

   integer     seed = 4939;
   logic [1:0] delay_r;
   logic [1:0] wait_r;
   logic [5:0] idx;
   logic       in_err;

   // Only the low dword bits select an entry, so upper space aliases
   assign idx    = adr_i[5:0];
   assign in_err = ({adr_i, 3'b000} >= err_base_addr_lp);

   always @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         ack_o   <= 1'b0;
         err_o   <= 1'b0;
         dat_o   <= '0;
         wait_r  <= '0;
         delay_r <= 2'($unsigned($random(seed)) % 4);
         // Fill depends on every index bit
         for (int i = 0; i < 64; i++)
         begin
            mem[i] <= {8{i[7:0]}} ^ 64'h5a3c_96f0_0f69_c3a5;
         end
      end
      else if (ack_o || err_o)
      begin
         // Master drops cyc next, pick a fresh delay
         ack_o   <= 1'b0;
         err_o   <= 1'b0;
         wait_r  <= '0;
         delay_r <= 2'($unsigned($random(seed)) % 4);
      end
      else if (cyc_i && stb_i)
      begin
         if (wait_r != delay_r)
         begin
            wait_r <= wait_r + 2'd1;
         end
         else if (in_err)
         begin
            // Faulting region, memory left alone
            err_o <= 1'b1;
         end
         else
         begin
            ack_o <= 1'b1;
            dat_o <= mem[idx];
            if (we_i)
            begin
               for (int b = 0; b < wb_sel_width_lp; b++)
               begin
                  if (sel_i[b])
                  begin
                     mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
                  end
               end
               log_adr.push_back(adr_i);
               log_dat.push_back(dat_i);
               log_sel.push_back(sel_i);
            end
         end
      end
   end

endmodule

//--- verilog.f
rtl/soc_mem_pkg.sv
rtl/mem_chan_if.sv
rtl/boot_cfg_sequencer.sv
rtl/mem_wb_bridge.sv
rtl/soc_mem_top.sv
tb/tb_wb_mem.sv
tb/tb_soc_mem_top.sv
